/* dcache_pkg.sv */
package dcache_pkg;

	// Width of one data word on both the master and the slave bus.
	localparam int word_bits = 32;

	// One select bit per byte of a word.
	localparam int sel_bits = word_bits / 8;

	// Addresses count words, so the byte offset bits are dropped.
	localparam int addr_bits = word_bits - $clog2(sel_bits);

	typedef logic [word_bits-1:0] word_t;

	typedef logic [addr_bits-1:0] addr_t;

	typedef logic [sel_bits-1:0] sel_t;

	// Bus op codes shared by the master and the slave port.
	typedef enum logic [1:0] {
		pi_noop = 2'b00,
		pi_wrop = 2'b01,
		pi_rdop = 2'b10
	} pi_op_e;

endpackage

/* dcache_store.sv */
`timescale 1ns/1ps

module dcache_store #(
	parameter int set_count = 8,
	parameter int way_count = 2
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              crst_i,
	input  logic              look_en_i,
	input  dcache_pkg::addr_t look_addr_i,
	input  dcache_pkg::sel_t  look_sel_i,
	output logic              hit_o,
	output dcache_pkg::word_t rd_data_o,
	output logic              sweeping_o,
	input  logic              wr_en_i,
	input  dcache_pkg::addr_t wr_addr_i,
	input  dcache_pkg::word_t wr_data_i,
	input  dcache_pkg::sel_t  wr_sel_i,
	input  logic              fill_en_i,
	input  dcache_pkg::word_t fill_data_i
);

	localparam int set_bits = $clog2(set_count);
	localparam int way_bits = (way_count > 1) ? $clog2(way_count) : 1;
	localparam int tag_bits = dcache_pkg::addr_bits - set_bits;

	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [set_bits-1:0] set_idx_t;
	typedef logic [way_bits-1:0] way_idx_t;

	tag_t              tag_mem   [way_count][set_count];
	dcache_pkg::word_t data_mem  [way_count][set_count];
	dcache_pkg::sel_t  valid_mem [way_count][set_count];

	dcache_pkg::addr_t look_addr_q;
	dcache_pkg::sel_t  look_sel_q;
	set_idx_t          look_set;
	tag_t              look_tag;
	set_idx_t          wr_set;
	tag_t              wr_tag;
	logic              wr_match;
	way_idx_t          match_way;
	way_idx_t          wr_way;
	way_idx_t          victim_q;
	logic              store_en;
	dcache_pkg::word_t store_data;
	logic              sweep_q;
	set_idx_t          sweep_idx_q;

	// The lookup address is registered, so the result appears one cycle later.
	always_ff @(posedge clk_i) begin
		if (look_en_i) begin
			look_addr_q <= look_addr_i;
			look_sel_q  <= look_sel_i;
		end
	end

	assign look_set = look_addr_q[set_bits-1:0];
	assign look_tag = look_addr_q[dcache_pkg::addr_bits-1:set_bits];
	assign wr_set   = wr_addr_i[set_bits-1:0];
	assign wr_tag   = wr_addr_i[dcache_pkg::addr_bits-1:set_bits];

	// A read hits only if every byte it selects is valid in the matching way.
	always_comb begin
		hit_o     = 1'b0;
		rd_data_o = data_mem[0][look_set];
		for (int w = 0; w < way_count; w++) begin
			if (tag_mem[w][look_set] == look_tag && valid_mem[w][look_set] != '0 &&
			    (valid_mem[w][look_set] & look_sel_q) == look_sel_q) begin
				hit_o     = 1'b1;
				rd_data_o = data_mem[w][look_set];
			end
		end
	end

	// Find the way that already holds the written line, if any.
	always_comb begin
		wr_match  = 1'b0;
		match_way = '0;
		for (int w = 0; w < way_count; w++) begin
			if (tag_mem[w][wr_set] == wr_tag && valid_mem[w][wr_set] != '0) begin
				wr_match  = 1'b1;
				match_way = way_idx_t'(w);
			end
		end
	end

	assign wr_way     = wr_match ? match_way : victim_q;
	assign store_en   = wr_en_i || fill_en_i;
	assign store_data = fill_en_i ? fill_data_i : wr_data_i;

	always_ff @(posedge clk_i) begin
		if (store_en) begin
			tag_mem[wr_way][wr_set] <= wr_tag;
			for (int b = 0; b < dcache_pkg::sel_bits; b++) begin
				if (fill_en_i || wr_sel_i[b])
					data_mem[wr_way][wr_set][8*b +: 8] <= store_data[8*b +: 8];
			end
			// A fresh victim keeps only the bytes just written.
			if (fill_en_i)
				valid_mem[wr_way][wr_set] <= '1;
			else if (wr_match)
				valid_mem[wr_way][wr_set] <= valid_mem[wr_way][wr_set] | wr_sel_i;
			else
				valid_mem[wr_way][wr_set] <= wr_sel_i;
		end
		if (sweep_q) begin
			for (int w = 0; w < way_count; w++)
				valid_mem[w][sweep_idx_q] <= '0;
		end
	end

	// The round-robin victim advances only when a line is allocated.
	always_ff @(posedge clk_i) begin
		if (rst_i)
			victim_q <= '0;
		else if (store_en && !wr_match)
			victim_q <= (victim_q == way_idx_t'(way_count - 1)) ? '0 : victim_q + 1'b1;
	end

	// The sweep clears one set per cycle across all ways.
	always_ff @(posedge clk_i) begin
		if (rst_i || crst_i) begin
			sweep_q     <= 1'b1;
			sweep_idx_q <= '0;
		end else if (sweep_q) begin
			sweep_idx_q <= sweep_idx_q + 1'b1;
			if (sweep_idx_q == set_idx_t'(set_count - 1))
				sweep_q <= 1'b0;
		end
	end

	assign sweeping_o = sweep_q;

endmodule

/* dcache_front.sv */
`timescale 1ns/1ps

module dcache_front (
	input  logic               clk_i,
	input  logic               rst_i,
	input  dcache_pkg::pi_op_e m_op_i,
	input  dcache_pkg::addr_t  m_addr_i,
	input  dcache_pkg::word_t  m_data_i,
	input  dcache_pkg::sel_t   m_sel_i,
	output dcache_pkg::word_t  m_data_o,
	output logic               m_rdy_o,
	output logic               look_en_o,
	output dcache_pkg::addr_t  look_addr_o,
	output dcache_pkg::sel_t   look_sel_o,
	input  logic               hit_i,
	input  dcache_pkg::word_t  rd_data_i,
	input  logic               sweeping_i,
	output logic               wr_en_o,
	output dcache_pkg::addr_t  wr_addr_o,
	output dcache_pkg::word_t  wr_data_o,
	output dcache_pkg::sel_t   wr_sel_o,
	output logic               fill_en_o,
	output dcache_pkg::word_t  fill_data_o,
	output logic               push_o,
	input  logic               near_full_i,
	output logic               fill_req_o,
	output dcache_pkg::addr_t  fill_addr_o,
	input  logic               fill_ack_i,
	input  dcache_pkg::word_t  fill_data_i
);

	typedef enum logic [1:0] {
		st_idle,
		st_lookup,
		st_miss_wait,
		st_release
	} front_state_e;

	front_state_e       state_q;
	logic               fill_req_q;
	dcache_pkg::pi_op_e op_q;
	dcache_pkg::addr_t  addr_q;
	dcache_pkg::word_t  data_q;
	dcache_pkg::sel_t   sel_q;
	dcache_pkg::word_t  fill_q;
	logic               is_wr_q;
	logic               accept;

	assign is_wr_q = (op_q == dcache_pkg::pi_wrop);

	// Ready depends on the state; a read hit keeps the port open back to back.
	always_comb begin
		m_rdy_o = 1'b0;
		case (state_q)
			st_idle:    m_rdy_o = !sweeping_i && !near_full_i;
			st_lookup:  m_rdy_o = !is_wr_q && hit_i;
			st_release: m_rdy_o = !fill_ack_i && !sweeping_i;
			default:    m_rdy_o = 1'b0;
		endcase
	end

	assign accept = m_rdy_o && (m_op_i != dcache_pkg::pi_noop);

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_q   <= m_op_i;
			addr_q <= m_addr_i;
			data_q <= m_data_i;
			sel_q  <= m_sel_i;
		end
		if (fill_en_o)
			fill_q <= fill_data_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q    <= st_idle;
			fill_req_q <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (accept)
						state_q <= st_lookup;
				end
				st_lookup: begin
					if (!is_wr_q && !hit_i) begin
						state_q    <= st_miss_wait;
						fill_req_q <= 1'b1;
					end else begin
						state_q <= accept ? st_lookup : st_idle;
					end
				end
				st_miss_wait: begin
					if (fill_ack_i) begin
						state_q    <= st_release;
						fill_req_q <= 1'b0;
					end
				end
				default: begin
					// Wait here until the arbiter has dropped its ack.
					if (m_rdy_o)
						state_q <= accept ? st_lookup : st_idle;
				end
			endcase
		end
	end

	assign look_en_o   = accept;
	assign look_addr_o = m_addr_i;
	assign look_sel_o  = m_sel_i;

	// The write goes to the store and the buffer in the same cycle.
	assign wr_en_o   = (state_q == st_lookup) && is_wr_q;
	assign push_o    = wr_en_o;
	assign wr_addr_o = addr_q;
	assign wr_data_o = data_q;
	assign wr_sel_o  = sel_q;

	assign fill_en_o   = (state_q == st_miss_wait) && fill_ack_i;
	assign fill_data_o = fill_data_i;
	assign fill_req_o  = fill_req_q;
	assign fill_addr_o = addr_q;

	assign m_data_o = (state_q == st_release) ? fill_q : rd_data_i;

endmodule

/* dcache_write_buffer.sv */
`timescale 1ns/1ps

module dcache_write_buffer #(
	parameter int buf_depth = 4
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              push_i,
	input  dcache_pkg::addr_t push_addr_i,
	input  dcache_pkg::word_t push_data_i,
	input  dcache_pkg::sel_t  push_sel_i,
	output logic              near_full_o,
	output logic              empty_o,
	output logic              wb_req_o,
	output dcache_pkg::addr_t wb_addr_o,
	output dcache_pkg::word_t wb_data_o,
	output dcache_pkg::sel_t  wb_sel_o,
	input  logic              wb_ack_i
);

	localparam int ptr_bits = (buf_depth > 1) ? $clog2(buf_depth) : 1;
	localparam int cnt_bits = $clog2(buf_depth + 1);

	typedef logic [ptr_bits-1:0] ptr_t;
	typedef logic [cnt_bits-1:0] cnt_t;

	dcache_pkg::addr_t addr_mem [buf_depth];
	dcache_pkg::word_t data_mem [buf_depth];
	dcache_pkg::sel_t  sel_mem  [buf_depth];

	ptr_t wr_ptr_q;
	ptr_t rd_ptr_q;
	cnt_t count_q;
	logic req_q;
	logic pop;

	function automatic ptr_t next_ptr(input ptr_t p);
		return (p == ptr_t'(buf_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	// The head entry leaves once its write has completed on the slave bus.
	assign pop = req_q && wb_ack_i;

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			addr_mem[wr_ptr_q] <= push_addr_i;
			data_mem[wr_ptr_q] <= push_data_i;
			sel_mem[wr_ptr_q]  <= push_sel_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			req_q    <= 1'b0;
		end else begin
			if (push_i)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			if (push_i && !pop)
				count_q <= count_q + 1'b1;
			else if (pop && !push_i)
				count_q <= count_q - 1'b1;
			// A new request waits until the previous ack has fallen.
			if (pop)
				req_q <= 1'b0;
			else if (!req_q && !wb_ack_i && (count_q != '0 || push_i))
				req_q <= 1'b1;
		end
	end

	assign wb_req_o    = req_q;
	assign wb_addr_o   = addr_mem[rd_ptr_q];
	assign wb_data_o   = data_mem[rd_ptr_q];
	assign wb_sel_o    = sel_mem[rd_ptr_q];
	assign empty_o     = (count_q == '0);
	assign near_full_o = (count_q >= cnt_t'(buf_depth - 1));

endmodule

/* dcache_bus_arbiter.sv */
`timescale 1ns/1ps

module dcache_bus_arbiter (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               wb_req_i,
	input  dcache_pkg::addr_t  wb_addr_i,
	input  dcache_pkg::word_t  wb_data_i,
	input  dcache_pkg::sel_t   wb_sel_i,
	input  logic               wb_empty_i,
	output logic               wb_ack_o,
	input  logic               fill_req_i,
	input  dcache_pkg::addr_t  fill_addr_i,
	output logic               fill_ack_o,
	output dcache_pkg::word_t  fill_data_o,
	output dcache_pkg::pi_op_e s_op_o,
	output dcache_pkg::addr_t  s_addr_o,
	output dcache_pkg::word_t  s_data_o,
	output dcache_pkg::sel_t   s_sel_o,
	input  dcache_pkg::word_t  s_data_i,
	input  logic               s_rdy_i
);

	typedef enum logic [1:0] {
		arb_idle,
		arb_busy,
		arb_ack
	} arb_state_e;

	arb_state_e        state_q;
	logic              owner_fill_q;
	logic              wb_ack_q;
	logic              fill_ack_q;
	dcache_pkg::word_t fill_data_q;
	logic              pick_fill;
	logic              use_fill;
	logic              issue;

	// Posted writes go first; a fill waits until the buffer is drained.
	assign pick_fill = fill_req_i && !wb_req_i && wb_empty_i;
	assign use_fill  = (state_q == arb_idle) ? pick_fill : owner_fill_q;
	assign issue     = (state_q == arb_idle) && s_rdy_i && (wb_req_i || pick_fill);

	always_comb begin
		s_op_o = dcache_pkg::pi_noop;
		if (issue)
			s_op_o = use_fill ? dcache_pkg::pi_rdop : dcache_pkg::pi_wrop;
	end

	assign s_addr_o = use_fill ? fill_addr_i : wb_addr_i;
	assign s_data_o = wb_data_i;
	assign s_sel_o  = use_fill ? '1 : wb_sel_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q      <= arb_idle;
			owner_fill_q <= 1'b0;
			wb_ack_q     <= 1'b0;
			fill_ack_q   <= 1'b0;
		end else begin
			case (state_q)
				arb_idle: begin
					if (issue) begin
						owner_fill_q <= use_fill;
						state_q      <= arb_busy;
					end
				end
				arb_busy: begin
					// The next ready cycle completes the command.
					if (s_rdy_i) begin
						fill_ack_q <= owner_fill_q;
						wb_ack_q   <= !owner_fill_q;
						state_q    <= arb_ack;
					end
				end
				default: begin
					if (owner_fill_q ? !fill_req_i : !wb_req_i) begin
						fill_ack_q <= 1'b0;
						wb_ack_q   <= 1'b0;
						state_q    <= arb_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == arb_busy && s_rdy_i && owner_fill_q)
			fill_data_q <= s_data_i;
	end

	assign wb_ack_o    = wb_ack_q;
	assign fill_ack_o  = fill_ack_q;
	assign fill_data_o = fill_data_q;

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
	parameter int set_count = 8,
	parameter int way_count = 2,
	parameter int buf_depth = 4
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               crst_i,
	input  dcache_pkg::pi_op_e m_op_i,
	input  dcache_pkg::addr_t  m_addr_i,
	input  dcache_pkg::word_t  m_data_i,
	input  dcache_pkg::sel_t   m_sel_i,
	output dcache_pkg::word_t  m_data_o,
	output logic               m_rdy_o,
	output dcache_pkg::pi_op_e s_op_o,
	output dcache_pkg::addr_t  s_addr_o,
	output dcache_pkg::word_t  s_data_o,
	output dcache_pkg::sel_t   s_sel_o,
	input  dcache_pkg::word_t  s_data_i,
	input  logic               s_rdy_i
);

	// Lookup and update path between the front end and the store.
	logic              look_en;
	dcache_pkg::addr_t look_addr;
	dcache_pkg::sel_t  look_sel;
	logic              hit;
	dcache_pkg::word_t rd_data;
	logic              sweeping;
	logic              wr_en;
	dcache_pkg::addr_t wr_addr;
	dcache_pkg::word_t wr_data;
	dcache_pkg::sel_t  wr_sel;
	logic              fill_en;
	dcache_pkg::word_t store_fill_data;

	// Posted writes and the write buffer request.
	logic              push;
	logic              near_full;
	logic              wb_empty;
	logic              wb_req;
	logic              wb_ack;
	dcache_pkg::addr_t wb_addr;
	dcache_pkg::word_t wb_data;
	dcache_pkg::sel_t  wb_sel;

	// Miss fill request.
	logic              fill_req;
	logic              fill_ack;
	dcache_pkg::addr_t fill_addr;
	dcache_pkg::word_t arb_fill_data;

	dcache_front u_front (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.m_op_i      (m_op_i),
		.m_addr_i    (m_addr_i),
		.m_data_i    (m_data_i),
		.m_sel_i     (m_sel_i),
		.m_data_o    (m_data_o),
		.m_rdy_o     (m_rdy_o),
		.look_en_o   (look_en),
		.look_addr_o (look_addr),
		.look_sel_o  (look_sel),
		.hit_i       (hit),
		.rd_data_i   (rd_data),
		.sweeping_i  (sweeping),
		.wr_en_o     (wr_en),
		.wr_addr_o   (wr_addr),
		.wr_data_o   (wr_data),
		.wr_sel_o    (wr_sel),
		.fill_en_o   (fill_en),
		.fill_data_o (store_fill_data),
		.push_o      (push),
		.near_full_i (near_full),
		.fill_req_o  (fill_req),
		.fill_addr_o (fill_addr),
		.fill_ack_i  (fill_ack),
		.fill_data_i (arb_fill_data)
	);

	dcache_store #(
		.set_count (set_count),
		.way_count (way_count)
	) u_store (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.crst_i      (crst_i),
		.look_en_i   (look_en),
		.look_addr_i (look_addr),
		.look_sel_i  (look_sel),
		.hit_o       (hit),
		.rd_data_o   (rd_data),
		.sweeping_o  (sweeping),
		.wr_en_i     (wr_en),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.wr_sel_i    (wr_sel),
		.fill_en_i   (fill_en),
		.fill_data_i (store_fill_data)
	);

	dcache_write_buffer #(
		.buf_depth (buf_depth)
	) u_write_buffer (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.push_i      (push),
		.push_addr_i (wr_addr),
		.push_data_i (wr_data),
		.push_sel_i  (wr_sel),
		.near_full_o (near_full),
		.empty_o     (wb_empty),
		.wb_req_o    (wb_req),
		.wb_addr_o   (wb_addr),
		.wb_data_o   (wb_data),
		.wb_sel_o    (wb_sel),
		.wb_ack_i    (wb_ack)
	);

	dcache_bus_arbiter u_bus_arbiter (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.wb_req_i    (wb_req),
		.wb_addr_i   (wb_addr),
		.wb_data_i   (wb_data),
		.wb_sel_i    (wb_sel),
		.wb_empty_i  (wb_empty),
		.wb_ack_o    (wb_ack),
		.fill_req_i  (fill_req),
		.fill_addr_i (fill_addr),
		.fill_ack_o  (fill_ack),
		.fill_data_o (arb_fill_data),
		.s_op_o      (s_op_o),
		.s_addr_o    (s_addr_o),
		.s_data_o    (s_data_o),
		.s_sel_o     (s_sel_o),
		.s_data_i    (s_data_i),
		.s_rdy_i     (s_rdy_i)
	);

endmodule

/* dcache_props.sv */
`timescale 1ns/1ps

module dcache_props (
	input logic               clk_i,
	input logic               rst_i,
	input logic               wb_req_i,
	input logic               wb_ack_i,
	input logic               wb_empty_i,
	input logic               fill_req_i,
	input logic               fill_ack_i,
	input dcache_pkg::pi_op_e s_op_i,
	input logic               s_rdy_i
);

	// Each requester keeps its request up until the arbiter answers.
	assert property (@(posedge clk_i) disable iff (rst_i)
		wb_req_i && !wb_ack_i |=> wb_req_i)
		else $error("write buffer request fell before its ack");

	assert property (@(posedge clk_i) disable iff (rst_i)
		fill_req_i && !fill_ack_i |=> fill_req_i)
		else $error("fill request fell before its ack");

	// An ack only answers a live request.
	assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(wb_ack_i) |-> wb_req_i)
		else $error("write buffer ack rose without a request");

	assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(fill_ack_i) |-> fill_req_i)
		else $error("fill ack rose without a request");

	// The ack is released only once the request has gone.
	assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(wb_ack_i) |-> !wb_req_i)
		else $error("write buffer ack fell while the request was still high");

	assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(fill_ack_i) |-> !fill_req_i)
		else $error("fill ack fell while the request was still high");

	assert property (@(posedge clk_i) disable iff (rst_i)
		!s_rdy_i |-> s_op_i == dcache_pkg::pi_noop)
		else $error("slave op issued while the slave was not ready");

	// Fills are served only behind a drained write buffer.
	assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(fill_ack_i) |-> wb_empty_i)
		else $error("fill ack rose while the write buffer held entries");

endmodule

bind dcache_bus_arbiter dcache_props u_props (
	.clk_i      (clk_i),
	.rst_i      (rst_i),
	.wb_req_i   (wb_req_i),
	.wb_ack_i   (wb_ack_o),
	.wb_empty_i (wb_empty_i),
	.fill_req_i (fill_req_i),
	.fill_ack_i (fill_ack_o),
	.s_op_i     (s_op_o),
	.s_rdy_i    (s_rdy_i)
);

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

	localparam int set_count  = 8;
	localparam int way_count  = 2;
	localparam int buf_depth  = 4;
	localparam int mem_words  = 1024;
	localparam int wait_limit = 400;

	typedef struct packed {
		dcache_pkg::pi_op_e op;
		dcache_pkg::addr_t  addr;
		dcache_pkg::word_t  data;
		dcache_pkg::sel_t   sel;
	} cmd_t;

	logic               clk_i;
	logic               rst_i;
	logic               crst_i;
	dcache_pkg::pi_op_e m_op_i;
	dcache_pkg::addr_t  m_addr_i;
	dcache_pkg::word_t  m_data_i;
	dcache_pkg::sel_t   m_sel_i;
	dcache_pkg::word_t  m_data_o;
	logic               m_rdy_o;
	dcache_pkg::pi_op_e s_op_o;
	dcache_pkg::addr_t  s_addr_o;
	dcache_pkg::word_t  s_data_o;
	dcache_pkg::sel_t   s_sel_o;
	dcache_pkg::word_t  s_data_i;
	logic               s_rdy_i;

	dcache_pkg::word_t shadow_mem [mem_words];
	dcache_pkg::word_t slave_mem  [mem_words];
	logic [31:0]       lfsr_q;
	cmd_t              exp_cmd_q  [$];
	string             cmd_name_q [$];
	string             exp_name_q [$];
	dcache_pkg::word_t exp_word_q [$];
	dcache_pkg::sel_t  exp_sel_q  [$];
	dcache_pkg::word_t act_word_q [$];
	int                mismatches;
	int                order_errors;
	int                timeouts;
	logic              aborted;

	dcache_top #(
		.set_count (set_count),
		.way_count (way_count),
		.buf_depth (buf_depth)
	) DUT (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.crst_i   (crst_i),
		.m_op_i   (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i  (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o  (m_rdy_o),
		.s_op_o   (s_op_o),
		.s_addr_o (s_addr_o),
		.s_data_o (s_data_o),
		.s_sel_o  (s_sel_o),
		.s_data_i (s_data_i),
		.s_rdy_i  (s_rdy_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// Initial memory contents are unique for every word index.
	function automatic dcache_pkg::word_t fill_word(input int unsigned idx);
		logic [9:0] a;
		a = idx[9:0];
		return {a, 6'h2a, ~a, 6'h15};
	endfunction

	function automatic dcache_pkg::word_t byte_mask(input dcache_pkg::sel_t sel);
		dcache_pkg::word_t m;
		for (int b = 0; b < dcache_pkg::sel_bits; b++)
			m[8*b +: 8] = {8{sel[b]}};
		return m;
	endfunction

	// The reference model merges the selected bytes of each write into the shadow memory.
	function automatic dcache_pkg::word_t ref_access(input dcache_pkg::pi_op_e op,
		input dcache_pkg::addr_t addr, input dcache_pkg::word_t data,
		input dcache_pkg::sel_t sel);
		dcache_pkg::word_t mask;
		mask = byte_mask(sel);
		if (op == dcache_pkg::pi_wrop)
			shadow_mem[addr[9:0]] = (shadow_mem[addr[9:0]] & ~mask) | (data & mask);
		return shadow_mem[addr[9:0]];
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v      = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		aborted = 1'b1;
		$display("timeout while waiting for %s", what);
	endtask

	// Leaves at the negedge of the first cycle in which m_rdy_o is high.
	task automatic wait_ready(input string what, output int waited);
		waited = 0;
		@(negedge clk_i);
		while (!m_rdy_o && !aborted) begin
			if (waited == wait_limit)
				report_timeout(what);
			else begin
				waited++;
				@(negedge clk_i);
			end
		end
	endtask

	task automatic write_word(input string name, input dcache_pkg::addr_t addr,
		input dcache_pkg::word_t data, input dcache_pkg::sel_t sel);
		int waited;
		if (!aborted) begin
			m_op_i   = dcache_pkg::pi_wrop;
			m_addr_i = addr;
			m_data_i = data;
			m_sel_i  = sel;
			wait_ready({name, " write acceptance"}, waited);
			@(posedge clk_i);
			#1;
			m_op_i = dcache_pkg::pi_noop;
			void'(ref_access(dcache_pkg::pi_wrop, addr, data, sel));
			exp_cmd_q.push_back(cmd_t'({dcache_pkg::pi_wrop, addr, data, sel}));
			cmd_name_q.push_back(name);
		end
	endtask

	task automatic read_word(input string name, input dcache_pkg::addr_t addr,
		input dcache_pkg::sel_t sel, input logic expect_miss);
		int waited;
		if (!aborted) begin
			m_op_i   = dcache_pkg::pi_rdop;
			m_addr_i = addr;
			m_sel_i  = sel;
			wait_ready({name, " read acceptance"}, waited);
			@(posedge clk_i);
			#1;
			m_op_i = dcache_pkg::pi_noop;
			exp_name_q.push_back(name);
			exp_word_q.push_back(ref_access(dcache_pkg::pi_rdop, addr, '0, sel));
			exp_sel_q.push_back(sel);
			// A miss must show up as one full-word slave read.
			if (expect_miss) begin
				exp_cmd_q.push_back(cmd_t'({dcache_pkg::pi_rdop, addr, 32'h0, 4'hf}));
				cmd_name_q.push_back(name);
			end
			wait_ready({name, " read data"}, waited);
			if (!aborted)
				act_word_q.push_back(m_data_o);
			assert (expect_miss || aborted || waited == 0) else begin
				mismatches++;
				$display("mismatch %s: hit latency expected 1, actual %0d", name, waited + 1);
			end
			@(posedge clk_i);
			#1;
		end
	endtask

	task automatic check_command(input cmd_t seen);
		cmd_t  want;
		string name;
		string exp_s;
		string act_s;
		assert (exp_cmd_q.size() != 0) else begin
			order_errors++;
			$display("slave command op %0d at address %h was issued but none was expected",
				seen.op, seen.addr);
		end
		if (exp_cmd_q.size() != 0) begin
			want = exp_cmd_q.pop_front();
			name = cmd_name_q.pop_front();
			if (want.op == dcache_pkg::pi_rdop)
				want.data = seen.data;
			exp_s = $sformatf("op %0d addr %h data %h sel %h", want.op, want.addr,
				want.data, want.sel);
			act_s = $sformatf("op %0d addr %h data %h sel %h", seen.op, seen.addr,
				seen.data, seen.sel);
			assert (seen === want) else begin
				order_errors++;
				$display("mismatch %s: expected %s, actual %s", name, exp_s, act_s);
			end
		end
	endtask

	task automatic drain_all();
		int waited;
		waited = 0;
		while (!aborted && (exp_cmd_q.size() != 0 || act_word_q.size() != 0)) begin
			if (waited == wait_limit)
				report_timeout("the outstanding slave commands and read results");
			else begin
				waited++;
				@(negedge clk_i);
			end
		end
		@(posedge clk_i);
		#1;
	endtask

	// Slave memory with a random stall of 0 to 3 cycles after each command.
	initial begin : slave_model
		cmd_t              seen;
		logic [31:0]       stall;
		dcache_pkg::word_t rd_word;
		dcache_pkg::word_t mask;
		s_rdy_i  = 1'b1;
		s_data_i = '0;
		for (int i = 0; i < mem_words; i++)
			slave_mem[i] = fill_word(i);
		forever begin
			@(negedge clk_i);
			if (s_rdy_i && s_op_o != dcache_pkg::pi_noop) begin
				seen = cmd_t'({s_op_o, s_addr_o, s_data_o, s_sel_o});
				check_command(seen);
				mask = byte_mask(s_sel_o);
				if (s_op_o == dcache_pkg::pi_wrop)
					slave_mem[s_addr_o[9:0]] = (slave_mem[s_addr_o[9:0]] & ~mask) |
						(s_data_o & mask);
				rd_word = slave_mem[s_addr_o[9:0]];
				take_bits(2, stall);
				@(posedge clk_i);
				#1;
				if (stall != 0) begin
					s_rdy_i = 1'b0;
					repeat (stall) begin
						@(posedge clk_i);
						#1;
					end
				end
				s_rdy_i  = 1'b1;
				s_data_i = rd_word;
			end
		end
	end

	// Compares read results in order with the words from the reference model.
	initial begin : compare_reads
		string             name;
		dcache_pkg::word_t mask;
		dcache_pkg::word_t exp_w;
		dcache_pkg::word_t act_w;
		forever begin
			@(posedge clk_i);
			while (act_word_q.size() != 0 && exp_word_q.size() != 0) begin
				name  = exp_name_q.pop_front();
				mask  = byte_mask(exp_sel_q.pop_front());
				exp_w = exp_word_q.pop_front() & mask;
				act_w = act_word_q.pop_front() & mask;
				assert (act_w === exp_w) else begin
					mismatches++;
					$display("mismatch %s: expected %h, actual %h", name, exp_w, act_w);
				end
			end
		end
	end

	initial begin : main_seq
		logic [31:0] rnd;
		logic [31:0] raddr;
		logic [31:0] rsel;
		int          sweep_cycles;
		rst_i        = 1'b1;
		crst_i       = 1'b0;
		m_op_i       = dcache_pkg::pi_noop;
		m_addr_i     = '0;
		m_data_i     = '0;
		m_sel_i      = '0;
		lfsr_q       = 32'he473fa05;
		mismatches   = 0;
		order_errors = 0;
		timeouts     = 0;
		aborted      = 1'b0;
		for (int i = 0; i < mem_words; i++)
			shadow_mem[i] = fill_word(i);
		repeat (5) @(posedge clk_i);
		#1;
		rst_i = 1'b0;

		write_word("write_read_hit", 30'h010, 32'hcafe0123, 4'hf);
		read_word("write_read_hit", 30'h010, 4'hf, 1'b0);

		read_word("read_miss_fill", 30'h021, 4'hf, 1'b1);
		read_word("read_miss_fill", 30'h021, 4'hf, 1'b0);

		// Byte 3 stays unwritten, so only a read that selects it misses.
		write_word("partial_select", 30'h032, 32'h1111abcd, 4'b0011);
		write_word("partial_select", 30'h032, 32'h00ee5555, 4'b0100);
		read_word("partial_select", 30'h032, 4'b0111, 1'b0);
		read_word("partial_select", 30'h032, 4'b1000, 1'b1);
		read_word("partial_select", 30'h032, 4'hf, 1'b0);

		write_word("posted_order", 30'h043, 32'h01020304, 4'b1001);
		write_word("posted_order", 30'h044, 32'h05060708, 4'b0110);
		write_word("posted_order", 30'h045, 32'h090a0b0c, 4'hf);
		write_word("posted_order", 30'h043, 32'hf0e0d0c0, 4'b0010);
		read_word("posted_order", 30'h106, 4'hf, 1'b1);

		crst_i = 1'b1;
		@(posedge clk_i);
		#1;
		crst_i       = 1'b0;
		sweep_cycles = 0;
		@(negedge clk_i);
		while (!m_rdy_o && !aborted) begin
			if (sweep_cycles == wait_limit)
				report_timeout("the end of the cache sweep");
			else begin
				sweep_cycles++;
				@(negedge clk_i);
			end
		end
		assert (sweep_cycles == set_count) else begin
			mismatches++;
			$display("mismatch cache_reset: sweep cycles expected %0d, actual %0d",
				set_count, sweep_cycles);
		end
		@(posedge clk_i);
		#1;
		read_word("cache_reset", 30'h021, 4'hf, 1'b1);
		read_word("cache_reset", 30'h010, 4'hf, 1'b1);

		// Random writes into a small window so some addresses repeat.
		for (int i = 0; i < 3 * buf_depth; i++) begin
			take_bits(4, raddr);
			take_bits(4, rsel);
			take_bits(32, rnd);
			if (rsel[3:0] == 4'h0)
				rsel = 32'hf;
			write_word("back_pressure", {26'h20, raddr[3:0]}, rnd, rsel[3:0]);
		end
		drain_all();
		for (int i = 0; i < mem_words; i++) begin
			assert (slave_mem[i] === shadow_mem[i]) else begin
				mismatches++;
				$display("mismatch back_pressure word %0d: expected %h, actual %h",
					i, shadow_mem[i], slave_mem[i]);
			end
		end

		$display("errors: %0d mismatches, %0d slave order errors, %0d timeouts",
			mismatches, order_errors, timeouts);
		if (mismatches + order_errors + timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* files.f */
dcache_pkg.sv
dcache_store.sv
dcache_front.sv
dcache_write_buffer.sv
dcache_bus_arbiter.sv
dcache_top.sv
dcache_props.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_store.sv
  - dcache_front.sv
  - dcache_write_buffer.sv
  - dcache_bus_arbiter.sv
  - dcache_top.sv
  - target: test
    files:
      - dcache_props.sv
      - tb_dcache.sv
